// File: design/masked_alu_defines.svh
`ifndef MASKED_ALU_DEFINES_SVH
`define MASKED_ALU_DEFINES_SVH

// Datapath width of every share
`define MASK_XLEN 32

// Kogge-Stone passes, log2 of the width
`define MASK_PREFIX_STAGES 5

// Prefix sequence counter limits
`define MASK_SEQ_FIRST 1
`define MASK_SEQ_DONE  6 // Sum is ready when the counter reaches this

// LFSR value after reset
`define MASK_PRNG_SEED 32'h6789ABCD

`endif

// File: design/mask_ops_pkg.sv
package mask_ops_pkg;

  // Operation select of the masked ALU
  typedef enum logic [3:0] {
    b_not    = 4'd0,
    b_and    = 4'd1,
    b_ior    = 4'd2,
    b_xor    = 4'd3,
    b_add    = 4'd4,
    b_sub    = 4'd5,
    b2a      = 4'd6,  // Boolean to arithmetic shares
    a2b      = 4'd7,  // Arithmetic to boolean shares
    b_mask   = 4'd8,
    b_unmask = 4'd9,
    b_remask = 4'd10,
    a_mask   = 4'd11,
    a_unmask = 4'd12,
    a_remask = 4'd13
  } alu_op_e;

  // Which unit carries the operation
  typedef enum logic [1:0] {
    cls_logic  = 2'd0, // Single pass through the logic unit
    cls_arith  = 2'd1, // Logic pass then prefix passes
    cls_remask = 2'd2  // Mask, unmask and remask
  } op_class_e;

endpackage

// File: design/mask_data_pkg.sv
`include "masked_alu_defines.svh"

package mask_data_pkg;

  // One share of a masked word
  typedef logic [`MASK_XLEN-1:0] share_t;

  // Counts prefix passes up to the done value
  typedef logic [$clog2(`MASK_SEQ_DONE+1)-1:0] seq_cnt_t;

endpackage

// File: design/alu_sequencer.sv
`timescale 1ns/100ps
`include "masked_alu_defines.svh"

module alu_sequencer import mask_ops_pkg::*, mask_data_pkg::*; (
  input  logic      g_clk,
  input  logic      g_resetn,
  input  logic      i_valid,
  input  logic      i_flush,
  input  alu_op_e   i_op,
  input  logic      i_logic_done,
  input  logic      i_sum_done,
  input  logic      i_mask_done,
  output logic      o_logic_ena,
  output logic      o_arith_ena,
  output op_class_e o_class,
  output logic      o_sub,
  output share_t    o_prng,
  output share_t    o_prng_next,
  output logic      o_ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_logic, // Logic result registered
    st_arith  // Prefix passes running
  } ctl_state_e;

  ctl_state_e state_q;
  logic       go;
  logic       do_logic;
  logic       do_arith;
  logic       do_pg;
  logic       prng_lsb;

  always_comb begin
    case (i_op)
      b_not, b_and, b_ior, b_xor: o_class = cls_logic;
      b_add, b_sub, b2a, a2b:     o_class = cls_arith;
      default:                    o_class = cls_remask;
    endcase
  end

  assign o_sub    = (i_op == b_sub) || (i_op == a2b); // a2b is a0 - a1
  assign go       = i_valid && !i_flush;
  assign do_logic = go && (o_class == cls_logic);
  assign do_arith = go && (o_class == cls_arith);
  assign do_pg    = do_logic || do_arith; // Both start with a logic pass

  always_ff @(posedge g_clk) begin
    if (!g_resetn || i_flush) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle:  if (do_pg) state_q <= i_logic_done ? (do_arith ? st_arith : st_idle) : st_logic;
        st_logic: state_q <= do_arith ? st_arith : st_idle;
        st_arith: state_q <= i_sum_done ? st_idle : st_arith;
        default:  state_q <= st_idle;
      endcase
    end
  end

  assign o_logic_ena = do_pg && (state_q == st_idle);
  assign o_arith_ena = do_arith && ((i_logic_done && state_q == st_idle) || state_q != st_idle);

  assign o_ready = !i_flush && ((do_logic && i_logic_done) || i_sum_done || i_mask_done);

  // Fresh masks, stepped once per finished operation
  assign prng_lsb    = o_prng[31] ~^ o_prng[21] ~^ o_prng[1] ~^ o_prng[0];
  assign o_prng_next = {o_prng[`MASK_XLEN-2:0], prng_lsb};

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_prng <= `MASK_PRNG_SEED;
    end else if (o_ready) begin
      o_prng <= o_prng_next;
    end
  end

  // Prefix passes only ever continue a logic pass or an earlier prefix pass
  a_arith_follows_pass : assert property (@(posedge g_clk) disable iff (!g_resetn)
    o_arith_ena |-> $past(o_logic_ena || o_arith_ena));

  a_single_logic_start : assert property (@(posedge g_clk) disable iff (!g_resetn)
    o_logic_ena |=> !o_logic_ena);

endmodule

// File: design/masked_logic.sv
`timescale 1ns/100ps

module masked_logic import mask_data_pkg::*; (
  input  logic   g_clk,
  input  logic   g_resetn,
  input  logic   i_ena,
  input  share_t i_gs,
  input  share_t i_a0,
  input  share_t i_a1,
  input  share_t i_b0,
  input  share_t i_b1,
  output share_t o_xor0,
  output share_t o_xor1,
  output share_t o_and0,
  output share_t o_and1,
  output share_t o_gs_fwd,
  output logic   o_done
);

  share_t t0_q;
  share_t t1_q;
  share_t t2_q;
  share_t t3_q;

  // Each AND term sees only one share of a, mask added to domain 0 terms
  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_xor0 <= '0;
      o_xor1 <= '0;
      t0_q   <= '0;
      t1_q   <= '0;
      t2_q   <= '0;
      t3_q   <= '0;
    end else if (i_ena) begin
      o_xor0 <= i_a0 ^ i_b0;      // Propagate shares
      o_xor1 <= i_a1 ^ i_b1;
      t0_q   <= i_gs ^ (i_a0 & i_b0);
      t1_q   <= i_gs ^ (i_a0 & i_b1);
      t2_q   <= i_a1 & i_b0;
      t3_q   <= i_a1 & i_b1;
    end
  end

  // Generate shares recombined after the register
  assign o_and0 = t0_q ^ t2_q;
  assign o_and1 = t1_q ^ t3_q;

  assign o_gs_fwd = i_a1; // Next stage reuses share a1 as its mask

  always_ff @(posedge g_clk) begin
    if (!g_resetn) o_done <= 1'b0;
    else           o_done <= i_ena;
  end

endmodule

// File: design/prefix_stage.sv
`timescale 1ns/100ps
`include "masked_alu_defines.svh"

module prefix_stage import mask_data_pkg::*; (
  input  logic     g_clk,
  input  logic     g_resetn,
  input  logic     i_ena,
  input  logic     i_sub,
  input  seq_cnt_t i_seq,
  input  share_t   i_gs,
  input  share_t   i_pk0,
  input  share_t   i_pk1,
  input  share_t   i_gk0,
  input  share_t   i_gk1,
  output share_t   o_pk0,
  output share_t   o_pk1,
  output share_t   o_gk0,
  output share_t   o_gk1,
  output share_t   o_gs_fwd
);

  typedef logic [`MASK_PREFIX_STAGES-1:0] shamt_t;

  logic   seq_live;
  logic   last_pass;
  shamt_t shamt;
  share_t cin;
  share_t pj0;
  share_t pj1;
  share_t gj0;
  share_t gj1;
  share_t tg0_q, tg1_q, tg2_q, tg3_q;
  share_t tp0_q, tp1_q, tp2_q, tp3_q;

  assign seq_live  = (i_seq >= seq_cnt_t'(`MASK_SEQ_FIRST)) &&
                     (i_seq <= seq_cnt_t'(`MASK_PREFIX_STAGES));
  assign last_pass = (i_seq == seq_cnt_t'(`MASK_PREFIX_STAGES));

  // Distance 1, 2, 4, 8, 16 for passes 1 to 5
  assign shamt = seq_live ? shamt_t'(1) << (i_seq - seq_cnt_t'(1)) : '0;

  // Subtract carry enters just below the shifted-in span
  assign cin = seq_live ? share_t'(i_sub) << (shamt - shamt_t'(1)) : '0;

  always_comb begin
    gj0 = '0;
    gj1 = '0;
    pj0 = '0;
    pj1 = '0;
    if (seq_live) begin
      gj0 = i_gk0 << shamt;
      gj1 = (i_gk1 << shamt) | cin;
      if (!last_pass) begin // Propagate no longer needed after the last pass
        pj0 = i_pk0 << shamt;
        pj1 = i_pk1 << shamt;
      end
    end
  end

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      tg0_q <= '0;
      tg1_q <= '0;
      tg2_q <= '0;
      tg3_q <= '0;
      tp0_q <= '0;
      tp1_q <= '0;
      tp2_q <= '0;
      tp3_q <= '0;
    end else if (i_ena) begin
      tg0_q <= i_gk0 ^ (gj0 & i_pk0); // G = Gk ^ (Gj & Pk)
      tg1_q <= i_gk1 ^ (gj1 & i_pk0);
      tg2_q <= gj0 & i_pk1;
      tg3_q <= gj1 & i_pk1;
      tp0_q <= i_gs ^ (i_pk0 & pj0);  // P = Pk & Pj, remasked
      tp1_q <= i_gs ^ (i_pk0 & pj1);
      tp2_q <= i_pk1 & pj0;
      tp3_q <= i_pk1 & pj1;
    end
  end

  assign o_gk0 = tg0_q ^ tg2_q;
  assign o_gk1 = tg1_q ^ tg3_q;
  assign o_pk0 = tp0_q ^ tp2_q;
  assign o_pk1 = tp1_q ^ tp3_q;

  assign o_gs_fwd = i_pk0; // Mask for the following pass

endmodule

// File: design/masked_addsub.sv
`timescale 1ns/100ps
`include "masked_alu_defines.svh"

module masked_addsub import mask_data_pkg::*; (
  input  logic   g_clk,
  input  logic   g_resetn,
  input  logic   i_flush,
  input  logic   i_ena,
  input  logic   i_sub,
  input  share_t i_gs,
  input  share_t i_xor0,
  input  share_t i_xor1,
  input  share_t i_and0,
  input  share_t i_and1,
  output share_t o_s0,
  output share_t o_s1,
  output logic   o_done
);

  seq_cnt_t seq_cnt_q;
  logic     first_pass;
  share_t   gs_in, gs_fb;
  share_t   p0_in, p1_in, g0_in, g1_in;
  share_t   p0, p1, g0, g1;

  always_ff @(posedge g_clk) begin
    if (!g_resetn || i_flush) seq_cnt_q <= seq_cnt_t'(`MASK_SEQ_FIRST);
    else if (o_done)          seq_cnt_q <= seq_cnt_t'(`MASK_SEQ_FIRST);
    else if (i_ena)           seq_cnt_q <= seq_cnt_q + seq_cnt_t'(1);
  end

  assign first_pass = i_ena && (seq_cnt_q == seq_cnt_t'(`MASK_SEQ_FIRST));

  // Logic unit results on pass 1, stage feedback afterwards
  assign gs_in = first_pass ? i_gs   : gs_fb;
  assign p0_in = first_pass ? i_xor0 : p0;
  assign p1_in = first_pass ? i_xor1 : p1;
  assign g0_in = first_pass ? i_and0 : g0;
  assign g1_in = first_pass ? i_and1 : g1;

  prefix_stage prefix_stage_i (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_ena    (i_ena),
    .i_sub    (i_sub),
    .i_seq    (seq_cnt_q),
    .i_gs     (gs_in),
    .i_pk0    (p0_in),
    .i_pk1    (p1_in),
    .i_gk0    (g0_in),
    .i_gk1    (g1_in),
    .o_pk0    (p0),
    .o_pk1    (p1),
    .o_gk0    (g0),
    .o_gk1    (g1),
    .o_gs_fwd (gs_fb)
  );

  // Sum = P ^ (carries shifted up), carry-in on share 1
  assign o_s0 = i_xor0 ^ {g0[`MASK_XLEN-2:0], 1'b0};
  assign o_s1 = i_xor1 ^ {g1[`MASK_XLEN-2:0], i_sub};

  assign o_done = (seq_cnt_q == seq_cnt_t'(`MASK_SEQ_DONE));

  // Once started, the prefix passes run back to back until done
  a_passes_back_to_back : assert property (@(posedge g_clk) disable iff (!g_resetn)
    (seq_cnt_q != seq_cnt_t'(`MASK_SEQ_FIRST) && !o_done && !i_flush) |-> i_ena);

endmodule

// File: design/mask_convert.sv
`timescale 1ns/100ps

module mask_convert import mask_ops_pkg::*, mask_data_pkg::*; (
  input  logic      g_clk,
  input  logic      g_resetn,
  input  op_class_e i_class,
  input  logic      i_valid,
  input  logic      i_flush,
  input  alu_op_e   i_op,
  input  share_t    i_rs1_s0,
  input  share_t    i_rs1_s1,
  input  share_t    i_prng,
  output share_t    o_s0,
  output share_t    o_s1,
  output logic      o_done
);

  logic   active;
  logic   op_mask;
  logic   op_unmask;
  logic   op_remask;
  logic   bool_form;
  logic   mask_done_q;
  share_t m_a0_q;
  share_t xm_a0;

  assign active    = i_valid && !i_flush && (i_class == cls_remask);
  assign op_mask   = active && (i_op == b_mask   || i_op == a_mask);
  assign op_unmask = active && (i_op == b_unmask || i_op == a_unmask);
  assign op_remask = active && (i_op == b_remask || i_op == a_remask);
  assign bool_form = (i_op == b_mask) || (i_op == b_unmask) || (i_op == b_remask);

  // Share 0 with the fresh mask folded in, held for the output cycle
  always_ff @(posedge g_clk) begin
    if (op_mask || op_remask) begin
      m_a0_q <= bool_form ? (i_rs1_s0 ^ i_prng) : (i_rs1_s0 + i_prng);
    end
  end

  assign xm_a0 = op_unmask ? i_rs1_s0 : m_a0_q;

  // Removing share 1 leaves the value under the new mask only
  always_comb begin
    if (op_mask)        o_s0 = m_a0_q;
    else if (bool_form) o_s0 = xm_a0 ^ i_rs1_s1;
    else                o_s0 = xm_a0 - i_rs1_s1;
  end

  assign o_s1 = (op_mask || op_remask) ? i_prng : '0; // Unmask gives zero share 1

  always_ff @(posedge g_clk) begin
    if (!g_resetn)                                  mask_done_q <= 1'b0;
    else if ((op_mask || op_remask) && !mask_done_q) mask_done_q <= 1'b1;
    else                                            mask_done_q <= 1'b0;
  end

  assign o_done = op_unmask || mask_done_q;

endmodule

// File: design/masked_alu.sv
`timescale 1ns/100ps

module masked_alu import mask_ops_pkg::*, mask_data_pkg::*; (
  input  logic    g_clk,
  input  logic    g_resetn,
  input  logic    i_valid,
  input  logic    i_flush,
  input  alu_op_e i_op,
  input  share_t  i_rs1_s0,
  input  share_t  i_rs1_s1,
  input  share_t  i_rs2_s0,
  input  share_t  i_rs2_s1,
  output logic    o_ready,
  output share_t  o_rd_s0,
  output share_t  o_rd_s1
);

  logic      do_not, do_ior, do_sub, do_b2a, do_a2b;
  logic      logic_ena, arith_ena, sub;
  logic      logic_done, sum_done, mask_done;
  op_class_e op_class;
  share_t    prng, prng_next;
  share_t    s_a1, s_b1, n_b0, n_b1;
  share_t    op_a1, op_b0, op_b1;
  share_t    xor0, xor1, and0, and1, gs_fwd;
  share_t    sum0, sum1, msk0, msk1;

  assign do_not = (i_op == b_not);
  assign do_ior = (i_op == b_ior);
  assign do_sub = (i_op == b_sub);
  assign do_b2a = (i_op == b2a);
  assign do_a2b = (i_op == a2b);

  // OR by De Morgan, subtract by complemented b, inverted via share 1
  assign s_a1 = do_ior ? ~i_rs1_s1 : i_rs1_s1;
  assign s_b1 = (do_ior || do_sub) ? ~i_rs2_s1 : i_rs2_s1;
  assign n_b0 = do_not ? '0 : i_rs2_s0; // NOT is XOR with zero b
  assign n_b1 = do_not ? '0 : s_b1;

  // b2a adds the fresh mask as b, a2b subtracts share 1 from share 0
  assign op_a1 = do_b2a ? i_rs1_s1 : (do_a2b ? '0 : s_a1);
  assign op_b0 = do_b2a ? prng : (do_a2b ? ~i_rs1_s1 : n_b0);
  assign op_b1 = (do_b2a || do_a2b) ? '0 : n_b1;

  alu_sequencer alu_sequencer_i (
    .g_clk(g_clk), .g_resetn(g_resetn),
    .i_valid(i_valid), .i_flush(i_flush), .i_op(i_op),
    .i_logic_done(logic_done), .i_sum_done(sum_done), .i_mask_done(mask_done),
    .o_logic_ena(logic_ena), .o_arith_ena(arith_ena),
    .o_class(op_class), .o_sub(sub),
    .o_prng(prng), .o_prng_next(prng_next), .o_ready(o_ready)
  );

  masked_logic masked_logic_i (
    .g_clk(g_clk), .g_resetn(g_resetn), .i_ena(logic_ena), .i_gs(prng_next),
    .i_a0(i_rs1_s0), .i_a1(op_a1), .i_b0(op_b0), .i_b1(op_b1),
    .o_xor0(xor0), .o_xor1(xor1), .o_and0(and0), .o_and1(and1),
    .o_gs_fwd(gs_fwd), .o_done(logic_done)
  );

  masked_addsub masked_addsub_i (
    .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(i_flush),
    .i_ena(arith_ena), .i_sub(sub), .i_gs(gs_fwd),
    .i_xor0(xor0), .i_xor1(xor1), .i_and0(and0), .i_and1(and1),
    .o_s0(sum0), .o_s1(sum1), .o_done(sum_done)
  );

  mask_convert mask_convert_i (
    .g_clk(g_clk), .g_resetn(g_resetn), .i_class(op_class),
    .i_valid(i_valid), .i_flush(i_flush), .i_op(i_op),
    .i_rs1_s0(i_rs1_s0), .i_rs1_s1(i_rs1_s1), .i_prng(prng),
    .o_s0(msk0), .o_s1(msk1), .o_done(mask_done)
  );

  // Result gather, valid only while o_ready is high
  always_comb begin
    case (i_op)
      b_not: begin
        o_rd_s0 = xor0;
        o_rd_s1 = ~xor1;
      end
      b_xor: begin
        o_rd_s0 = xor0;
        o_rd_s1 = xor1;
      end
      b_and: begin
        o_rd_s0 = and0;
        o_rd_s1 = and1;
      end
      b_ior: begin
        o_rd_s0 = and0;
        o_rd_s1 = ~and1; // Undo the De Morgan inversion
      end
      b_add, b_sub, a2b: begin
        o_rd_s0 = sum0;
        o_rd_s1 = sum1;
      end
      b2a: begin
        o_rd_s0 = sum0 ^ sum1; // x + mask, with the mask as share 1
        o_rd_s1 = prng;
      end
      default: begin
        o_rd_s0 = msk0;
        o_rd_s1 = msk1;
      end
    endcase
  end

endmodule

// File: test/tb_masked_alu.sv
`timescale 1ns/100ps

module tb_masked_alu import mask_ops_pkg::*, mask_data_pkg::*; ();

  localparam int RESET_CYCLES    = 10;
  localparam int CYCLES_PER_LINE = 16;
  localparam int ARITH_LATENCY   = 7;  // Logic pass plus five prefix passes
  localparam int FLUSH_AFTER     = 3;  // Flush lands inside the prefix passes
  localparam int FLUSH_QUIET     = 10;
  localparam int KIND_BOOL       = 0;
  localparam int KIND_ARITH      = 1;
  localparam int KIND_PLAIN      = 2;

  logic    g_clk;
  logic    g_resetn;
  logic    i_valid;
  logic    i_flush;
  alu_op_e i_op;
  share_t  i_rs1_s0;
  share_t  i_rs1_s1;
  share_t  i_rs2_s0;
  share_t  i_rs2_s1;
  logic    o_ready;
  share_t  o_rd_s0;
  share_t  o_rd_s1;

  // One entry per golden line
  alu_op_e vec_op[$];
  share_t  vec_a0[$];
  share_t  vec_a1[$];
  share_t  vec_b0[$];
  share_t  vec_b1[$];
  share_t  vec_exp[$];

  int cycle_cnt     = 0;
  int timeout_limit = RESET_CYCLES + CYCLES_PER_LINE;
  int err_cnt       = 0;
  int pass_cnt      = 0;
  int fail_cnt      = 0;
  bit flush_done    = 1'b0;

  masked_alu masked_alu_i (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_valid  (i_valid),
    .i_flush  (i_flush),
    .i_op     (i_op),
    .i_rs1_s0 (i_rs1_s0),
    .i_rs1_s1 (i_rs1_s1),
    .i_rs2_s0 (i_rs2_s0),
    .i_rs2_s1 (i_rs2_s1),
    .o_ready  (o_ready),
    .o_rd_s0  (o_rd_s0),
    .o_rd_s1  (o_rd_s1)
  );

  always #5 g_clk = ~g_clk;

  always @(posedge g_clk) begin
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout after %0d cycles, the DUT never finished the tests", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      cycle_cnt = cycle_cnt + 1;
    end
  end

  function automatic bit load_golden();
    int     fd;
    int     rc;
    int     code;
    string  line;
    share_t f0, f1, f2, f3, fe;
    fd = $fopen("test/masked_alu_golden.txt", "r");
    if (fd == 0) return 1'b0;
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      // Comment and blank lines do not parse as six words
      if (rc > 0 && $sscanf(line, "%h %h %h %h %h %h", code, f0, f1, f2, f3, fe) == 6) begin
        vec_op.push_back(alu_op_e'(code[3:0]));
        vec_a0.push_back(f0);
        vec_a1.push_back(f1);
        vec_b0.push_back(f2);
        vec_b1.push_back(f3);
        vec_exp.push_back(fe);
      end
    end
    $fclose(fd);
    return vec_op.size() > 0;
  endfunction

  function automatic bit uses_prefix(alu_op_e op);
    return (op == b_add) || (op == b_sub) || (op == b2a) || (op == a2b);
  endfunction

  // How the output shares recombine to the plain value
  function automatic int unmask_kind(alu_op_e op);
    case (op)
      b2a, a_mask, a_remask: return KIND_ARITH;
      b_unmask, a_unmask:    return KIND_PLAIN;
      default:               return KIND_BOOL;
    endcase
  endfunction

  task automatic check_bool_result(share_t s0, share_t s1, share_t exp, string name);
    share_t got;
    got = s0 ^ s1;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s xor of shares %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_arith_result(share_t s0, share_t s1, share_t exp, string name);
    share_t got;
    got = s0 - s1;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s share difference %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_plain_result(share_t s0, share_t s1, share_t exp, string name);
    if (s0 !== exp) begin
      $display("Mismatch at %0t: %s share 0 %h, expected %h", $time, name, s0, exp);
      err_cnt++;
    end
    if (s1 !== '0) begin
      $display("Mismatch at %0t: %s share 1 %h, expected zero", $time, name, s1);
      err_cnt++;
    end
  endtask

  task automatic expect_no_ready(string when);
    if (o_ready !== 1'b0) begin
      $display("o_ready was high %s at %0t", when, $time);
      err_cnt++;
    end
  endtask

  task automatic log_test_end(string name, int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("%0t  %s  ok", $time, name);
    end else begin
      fail_cnt++;
      $display("%0t  %s  FAILED", $time, name);
    end
  endtask

  task automatic clear_inputs();
    i_valid  = 1'b0;
    i_flush  = 1'b0;
    i_op     = b_not;
    i_rs1_s0 = '0;
    i_rs1_s1 = '0;
    i_rs2_s0 = '0;
    i_rs2_s1 = '0;
  endtask

  task automatic drive_op(int idx);
    @(negedge g_clk);
    i_op     = vec_op[idx];
    i_rs1_s0 = vec_a0[idx];
    i_rs1_s1 = vec_a1[idx];
    i_rs2_s0 = vec_b0[idx];
    i_rs2_s1 = vec_b1[idx];
    i_valid  = 1'b1;
  endtask

  task automatic check_quiet_after_reset();
    int errs_before;
    errs_before = err_cnt;
    repeat (3) begin
      @(negedge g_clk);
      expect_no_ready("after reset with no operation");
    end
    log_test_end("idle after reset", errs_before);
  endtask

  task automatic run_flushed_add(int idx);
    int errs_before;
    errs_before = err_cnt;
    drive_op(idx);
    repeat (FLUSH_AFTER) begin
      @(negedge g_clk);
      expect_no_ready("before the flush");
    end
    i_valid = 1'b0;
    i_flush = 1'b1;
    @(negedge g_clk);
    i_flush = 1'b0;
    repeat (FLUSH_QUIET) begin
      @(negedge g_clk);
      expect_no_ready("for a flushed add");
    end
    log_test_end("flush during b_add", errs_before);
  endtask

  task automatic run_test(int idx);
    alu_op_e op;
    share_t  r0;
    share_t  r1;
    int      lat;
    int      errs_before;
    string   name;
    op          = vec_op[idx];
    errs_before = err_cnt;
    name        = $sformatf("line %0d %s", idx, op.name());
    drive_op(idx);
    lat = 0;
    do begin
      @(posedge g_clk);
      lat++;
      @(negedge g_clk);
    end while (o_ready !== 1'b1);
    r0 = o_rd_s0; // Only valid in the ready cycle
    r1 = o_rd_s1;
    @(posedge g_clk);
    lat++;        // Edge that closes the ready cycle
    @(negedge g_clk);
    clear_inputs();
    @(negedge g_clk);
    expect_no_ready("a second time for one operation");
    if (uses_prefix(op) && lat != ARITH_LATENCY) begin
      $display("Mismatch at %0t: %s ready after %0d cycles, expected %0d",
               $time, name, lat, ARITH_LATENCY);
      err_cnt++;
    end
    case (unmask_kind(op))
      KIND_ARITH: check_arith_result(r0, r1, vec_exp[idx], name);
      KIND_PLAIN: check_plain_result(r0, r1, vec_exp[idx], name);
      default:    check_bool_result(r0, r1, vec_exp[idx], name);
    endcase
    log_test_end(name, errs_before);
  endtask

  initial begin
    g_clk    = 1'b0;
    g_resetn = 1'b0;
    clear_inputs();
    if (!load_golden()) begin
      $display("Could not read any vectors from test/masked_alu_golden.txt");
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      timeout_limit = RESET_CYCLES + CYCLES_PER_LINE * vec_op.size();
      repeat (RESET_CYCLES) @(negedge g_clk);
      g_resetn = 1'b1;
      check_quiet_after_reset();
      for (int k = 0; k < vec_op.size(); k++) begin
        if (vec_op[k] == b_add && !flush_done) begin
          run_flushed_add(k); // Aborted first, then issued again below
          flush_done = 1'b1;
        end
        run_test(k);
      end
      $display("Tests passed: %0d  failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: test/masked_alu_golden.txt
// op rs1_s0 rs1_s1 rs2_s0 rs2_s1 expected, all hex
// op is the 4-bit operation code, expected is the plain unmasked result
0 EDCB5678 FFFF0000 DEADBEEF 01234567 EDCBA987
0 A5A5A5A5 A5A5A5A5 00000000 00000000 FFFFFFFF
1 FFFFFFFF 0F0F0F0F ED34A978 12345678 F000F000
1 EDCB5678 FFFF0000 A5A55A5A A5A5A5A5 00005678
1 FFFFFFFF 00000000 7654CDEF FFFF0000 89ABCDEF
2 FFFFFFFF 0F0F0F0F 0F0F0000 00000000 FFFFF0F0
2 EDCB5678 FFFF0000 ED34A978 12345678 FF34FF78
2 A5A5A5A5 A5A5A5A5 FFFF0000 FFFF0000 00000000
3 EDCB5678 FFFF0000 7654CDEF FFFF0000 9B9F9B97
3 FFFFFFFF 0F0F0F0F A5A55A5A A5A5A5A5 F0F00F0F
4 00000001 00000000 FFFFFFFF 00000000 00000000
4 EDCB5678 FFFF0000 7654CDEF FFFF0000 9BE02467
4 5A5A5A5A A5A5A5A5 F0F0F0F0 0F0F0F0F FFFFFFFE
4 8000FFFF FFFF0000 12345679 12345678 80000000
5 00000000 00000000 00000001 00000000 FFFFFFFF
5 7654CDEF FFFF0000 EDCB5678 FFFF0000 77777777
5 EDCB5678 FFFF0000 89ABCDEF 00000000 88888889
5 25A5A5A5 A5A5A5A5 0F0F0F0E 0F0F0F0F 7FFFFFFF
6 EDCB5678 FFFF0000 00000000 00000000 12345678
6 5A5A5A5A A5A5A5A5 00000000 00000000 FFFFFFFF
7 00000005 00000007 00000000 00000000 FFFFFFFE
7 9BE02467 89ABCDEF 00000000 00000000 12345678
8 CAFEF00D 00000000 00000000 00000000 CAFEF00D
8 00000000 00000000 00000000 00000000 00000000
9 EDCB5678 FFFF0000 00000000 00000000 12345678
9 A5A5A5A5 A5A5A5A5 00000000 00000000 00000000
A 7654CDEF FFFF0000 00000000 00000000 89ABCDEF
A FFFFFFFF 0F0F0F0F 00000000 00000000 F0F0F0F0
B 12345678 00000000 00000000 00000000 12345678
B FFFFFFFF 00000000 00000000 00000000 FFFFFFFF
C 9BE02467 89ABCDEF 00000000 00000000 12345678
C 00000000 00000001 00000000 00000000 FFFFFFFF
D 89ABCDEF 12345678 00000000 00000000 77777777
D 00000005 00000007 00000000 00000000 FFFFFFFE

// File: sources.f
+incdir+design
design/mask_ops_pkg.sv
design/mask_data_pkg.sv
design/alu_sequencer.sv
design/masked_logic.sv
design/prefix_stage.sv
design/masked_addsub.sv
design/mask_convert.sv
design/masked_alu.sv
test/tb_masked_alu.sv

// File: run_sim.sh
#!/bin/sh
# Compile the DUT and testbench with Verilator, run, and search the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
  --top-module tb_masked_alu -o tb_masked_alu \
  && ./obj_dir/tb_masked_alu \
    | awk '{ print } /TEST RESULT: PASS/ { found = 1 } END { exit !found }' \
  && echo "Simulation finished without failures" \
  || { echo "Simulation failed"; exit 1; }
